// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// ------------------------------------------------------------
	// primary opcodes, instr[30:25]
	// ------------------------------------------------------------
	localparam logic [5:0] op_ty_base = 6'b100000;
	localparam logic [5:0] op_addi    = 6'b101000;
	localparam logic [5:0] op_ori     = 6'b101100;
	localparam logic [5:0] op_xori    = 6'b101011;
	localparam logic [5:0] op_movi    = 6'b100010;
	localparam logic [5:0] op_lwi     = 6'b000010; // load/store, not supported here
	localparam logic [5:0] op_swi     = 6'b001010;
	localparam logic [5:0] op_ty_ls   = 6'b011100;
	localparam logic [5:0] op_ty_b    = 6'b100110; // branch group
	localparam logic [5:0] op_ty_j    = 6'b100100; // jump group

	// base type sub-opcodes, instr[4:0]
	localparam logic [4:0] sub_add   = 5'b00000;
	localparam logic [4:0] sub_sub   = 5'b00001;
	localparam logic [4:0] sub_and   = 5'b00010;
	localparam logic [4:0] sub_xor   = 5'b00011;
	localparam logic [4:0] sub_or    = 5'b00100;
	localparam logic [4:0] sub_slli  = 5'b01000;
	localparam logic [4:0] sub_srli  = 5'b01001;
	localparam logic [4:0] sub_rotri = 5'b01011;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_srl,
		alu_sll,
		alu_ror,
		alu_pass // result is src2
	} alu_op_e;

	// ------------------------------------------------------------
	// instruction word, register and immediate views
	// ------------------------------------------------------------
	typedef struct packed {
		logic       rsvd;
		logic [5:0] opcode;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [4:0] rsvd_mid;
		logic [4:0] sub_op;
	} r_form_t;

	typedef struct packed {
		logic        rsvd;
		logic [5:0]  opcode;
		logic [4:0]  rt;     // source and destination for addi/ori/xori
		logic [19:0] imm;    // imm15 sits in the low bits
	} i_form_t;

	typedef union packed {
		r_form_t r_form;
		i_form_t i_form;
	} instr_t;

	typedef struct packed {
		logic [4:0]  ra_idx;
		logic [4:0]  rb_idx;
		logic [4:0]  rd_idx;
		logic        use_imm;
		logic [31:0] imm;     // already extended
		alu_op_e     op;
		logic        write_en;
		logic        illegal;
	} decoded_t;

	// wishbone master outputs
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic [31:0] adr;
		logic        we;
	} wb_req_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [4:0]  rd;
		logic [31:0] result;
		logic        overflow;
		logic        illegal;
	} retire_t;

endpackage

`default_nettype wire

// File: alu.sv
`default_nettype none

module alu
	import cpu_pkg::*;
(
	input  logic        reset,
	input  logic        enable_execute,
	input  logic [31:0] alu_src1,
	input  logic [31:0] alu_src2,
	input  alu_op_e     op,
	output logic [31:0] alu_result,
	output logic        alu_overflow
);

	logic        carry_31;  // carry (or borrow) into bit 31
	logic        carry_out; // carry (or borrow) out of bit 31
	logic [63:0] rotate;
	logic [4:0]  shamt;

	assign shamt = alu_src2[4:0];

	always_comb begin
		carry_31 = 1'b0;
		carry_out = 1'b0;
		rotate = '0;
		alu_result = '0;
		alu_overflow = 1'b0;

		if (!reset && enable_execute) begin
			case (op)
				// split add so the two carries are visible
				alu_add: begin
					{carry_31, alu_result[30:0]} = {1'b0, alu_src1[30:0]} + {1'b0, alu_src2[30:0]};
					{carry_out, alu_result[31]} = {1'b0, alu_src1[31]} + {1'b0, alu_src2[31]}
						+ {1'b0, carry_31};
					alu_overflow = carry_31 ^ carry_out;
				end
				alu_sub: begin
					{carry_31, alu_result[30:0]} = {1'b0, alu_src1[30:0]} - {1'b0, alu_src2[30:0]};
					{carry_out, alu_result[31]} = {1'b0, alu_src1[31]} - {1'b0, alu_src2[31]}
						- {1'b0, carry_31};
					alu_overflow = carry_31 ^ carry_out; // borrows play the carry role
				end
				alu_and: begin
					alu_result = alu_src1 & alu_src2;
				end
				alu_or: begin
					alu_result = alu_src1 | alu_src2;
				end
				alu_xor: begin
					alu_result = alu_src1 ^ alu_src2;
				end

				// ------------------------------------------------------------
				// shifts, amount is the low five bits of src2
				// ------------------------------------------------------------
				alu_srl: begin
					alu_result = alu_src1 >> shamt;
				end
				alu_sll: begin
					alu_result = alu_src1 << shamt;
				end
				alu_ror: begin
					rotate = {alu_src1, alu_src1} >> shamt;
					alu_result = rotate[31:0];
				end
				alu_pass: begin
					alu_result = alu_src2; // movi and rejected instructions
				end
				default: begin
					alu_result = '0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: instr_decoder.sv
`default_nettype none

module instr_decoder
	import cpu_pkg::*;
(
	input  instr_t   instr,
	output decoded_t dec
);

	always_comb begin
		dec.ra_idx = instr.r_form.ra;
		dec.rb_idx = instr.r_form.rb;
		dec.rd_idx = instr.r_form.rt;
		dec.use_imm = 1'b0;
		dec.imm = '0;
		dec.op = alu_pass;
		dec.write_en = 1'b0;
		dec.illegal = 1'b0;

		case (instr.r_form.opcode)
			op_ty_base: begin
				dec.write_en = 1'b1;
				case (instr.r_form.sub_op)
					sub_add: dec.op = alu_add;
					sub_sub: dec.op = alu_sub;
					sub_and: dec.op = alu_and;
					sub_or:  dec.op = alu_or;
					sub_xor: dec.op = alu_xor;
					sub_srli, sub_slli, sub_rotri: begin
						dec.use_imm = 1'b1;
						dec.imm = {27'b0, instr.r_form.rb}; // rb field is the shift amount
						if (instr.r_form.sub_op == sub_srli)
							dec.op = alu_srl;
						else if (instr.r_form.sub_op == sub_slli)
							dec.op = alu_sll;
						else
							dec.op = alu_ror;
					end
					default: begin
						dec.write_en = 1'b0;
						dec.illegal = 1'b1;
						dec.use_imm = 1'b1; // pass of zero
					end
				endcase
			end

			// two operand immediate forms, rt is read and written
			op_addi, op_ori, op_xori: begin
				dec.ra_idx = instr.i_form.rt;
				dec.use_imm = 1'b1;
				dec.write_en = 1'b1;
				if (instr.i_form.opcode == op_addi) begin
					dec.imm = {{17{instr.i_form.imm[14]}}, instr.i_form.imm[14:0]};
					dec.op = alu_add;
				end else begin
					dec.imm = {17'b0, instr.i_form.imm[14:0]};
					dec.op = (instr.i_form.opcode == op_ori) ? alu_or : alu_xor;
				end
			end
			op_movi: begin
				dec.use_imm = 1'b1;
				dec.imm = {{12{instr.i_form.imm[19]}}, instr.i_form.imm};
				dec.write_en = 1'b1;
			end

			// memory and control flow are not implemented
			op_lwi, op_swi, op_ty_ls, op_ty_b, op_ty_j: begin
				dec.illegal = 1'b1;
				dec.use_imm = 1'b1;
			end
			default: begin
				dec.illegal = 1'b1;
				dec.use_imm = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: regfile.sv
`default_nettype none

module regfile (
	input  logic        clock,
	input  logic        reset,
	input  logic [4:0]  ra_idx,
	input  logic [4:0]  rb_idx,
	input  logic        we,
	input  logic [4:0]  wr_idx,
	input  logic [31:0] wr_data,
	output logic [31:0] ra_data,
	output logic [31:0] rb_data
);

	logic [31:0] regs [32];

	// r0 is an ordinary register in this core
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// asynchronous read ports
	assign ra_data = regs[ra_idx];
	assign rb_data = regs[rb_idx];

endmodule

`default_nettype wire

// File: fetch_unit.sv
`default_nettype none

module fetch_unit
	import cpu_pkg::*;
(
	input  logic        clock,
	input  logic        reset,
	input  logic [31:0] wb_dat_i,
	input  logic        wb_ack,
	output wb_req_t     wb_out,
	output logic        fetch_valid,
	output logic [31:0] fetch_pc,
	output instr_t      fetch_instr
);

	logic        req;    // bus cycle in progress
	logic [31:0] pc;     // address of the word being fetched
	logic        done;

	assign done = req && wb_ack;

	// ------------------------------------------------------------
	// request/idle control and program counter
	// ------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			req <= 1'b0;
			pc <= '0;
			fetch_valid <= 1'b0;
		end else begin
			fetch_valid <= done;
			if (done) begin
				req <= 1'b0; // one idle cycle while execute runs
				pc <= pc + 32'd4;
			end else if (!req) begin
				req <= 1'b1;
			end
		end
	end

	// instruction word and its address, captured on ack
	always_ff @(posedge clock) begin
		if (done) begin
			fetch_instr <= wb_dat_i;
			fetch_pc <= pc;
		end
	end

	assign wb_out.cyc = req;
	assign wb_out.stb = req;
	assign wb_out.adr = pc;
	assign wb_out.we = 1'b0; // read only master

endmodule

`default_nettype wire

// File: execute_stage.sv
`default_nettype none

module execute_stage
	import cpu_pkg::*;
(
	input  logic        clock,
	input  logic        reset,
	input  logic        fetch_valid,
	input  logic [31:0] fetch_pc,
	input  instr_t      fetch_instr,
	output retire_t     retire
);

	decoded_t    dec;
	logic [31:0] ra_data;
	logic [31:0] rb_data;
	logic [31:0] src2;
	logic [31:0] alu_result;
	logic        alu_overflow;
	logic        valid_q;

	instr_decoder u_dec (
		.instr (fetch_instr),
		.dec   (dec)
	);

	regfile u_rf (
		.clock   (clock),
		.reset   (reset),
		.ra_idx  (dec.ra_idx),
		.rb_idx  (dec.rb_idx),
		.we      (fetch_valid && dec.write_en),
		.wr_idx  (dec.rd_idx),
		.wr_data (alu_result),
		.ra_data (ra_data),
		.rb_data (rb_data)
	);

	assign src2 = dec.use_imm ? dec.imm : rb_data;

	alu u_alu (
		.reset          (reset),
		.enable_execute (fetch_valid),
		.alu_src1       (ra_data),
		.alu_src2       (src2),
		.op             (dec.op),
		.alu_result     (alu_result),
		.alu_overflow   (alu_overflow)
	);

	// ------------------------------------------------------------
	// retire record, valid one cycle after execute
	// ------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset)
			valid_q <= 1'b0;
		else
			valid_q <= fetch_valid;
	end

	always_ff @(posedge clock) begin
		if (fetch_valid) begin
			retire.pc <= fetch_pc;
			retire.rd <= dec.rd_idx;
			retire.result <= alu_result;
			retire.overflow <= alu_overflow;
			retire.illegal <= dec.illegal; // still retires, no write
		end
	end

	assign retire.valid = valid_q;

endmodule

`default_nettype wire

// File: core_top.sv
`default_nettype none

module core_top
	import cpu_pkg::*;
(
	input  logic        clock,
	input  logic        reset,
	output wb_req_t     wb_out,
	input  logic [31:0] wb_dat_i,
	input  logic        wb_ack,
	output retire_t     retire
);

	logic        fetch_valid;
	logic [31:0] fetch_pc;
	instr_t      fetch_instr;

	fetch_unit u_fetch (
		.clock       (clock),
		.reset       (reset),
		.wb_dat_i    (wb_dat_i),
		.wb_ack      (wb_ack),
		.wb_out      (wb_out),
		.fetch_valid (fetch_valid),
		.fetch_pc    (fetch_pc),
		.fetch_instr (fetch_instr)
	);

	// execute always accepts, no handshake back to fetch
	execute_stage u_exec (
		.clock       (clock),
		.reset       (reset),
		.fetch_valid (fetch_valid),
		.fetch_pc    (fetch_pc),
		.fetch_instr (fetch_instr),
		.retire      (retire)
	);

endmodule

`default_nettype wire

// File: core_assertions.sv
`default_nettype none

module core_assertions
	import cpu_pkg::*;
(
	input  logic    clock,
	input  logic    reset,
	input  wb_req_t wb_out,
	input  logic    wb_ack,
	input  retire_t retire
);
	timeunit 1ns;
	timeprecision 1ps;

	int assert_failures = 0; // read by the testbench summary

	// ------------------------------------------------------------
	// wishbone classic master rules
	// ------------------------------------------------------------
	stb_needs_cyc: assert property (@(posedge clock) disable iff (reset)
		wb_out.stb |-> wb_out.cyc)
	else begin
		assert_failures++;
		$error("stb high without cyc");
	end

	adr_held: assert property (@(posedge clock) disable iff (reset)
		wb_out.stb && !wb_ack |=> $stable(wb_out.adr))
	else begin
		assert_failures++;
		$error("adr changed before ack");
	end

	adr_aligned: assert property (@(posedge clock) disable iff (reset)
		wb_out.stb |-> wb_out.adr[1:0] == 2'b00)
	else begin
		assert_failures++;
		$error("adr not word aligned");
	end

	retire_gap: assert property (@(posedge clock) disable iff (reset)
		retire.valid |=> !retire.valid) // execute never retires back to back
	else begin
		assert_failures++;
		$error("retire valid two cycles in a row");
	end

endmodule

bind core_top core_assertions u_assert (
	.clock  (clock),
	.reset  (reset),
	.wb_out (wb_out),
	.wb_ack (wb_ack),
	.retire (retire)
);

`default_nettype wire

// File: core_tb.sv
`default_nettype none

module core_tb
	import cpu_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	logic        clock;
	logic        reset;
	logic [31:0] wb_dat_i;
	logic        wb_ack;
	wb_req_t     wb_out;
	retire_t     retire;

	logic [31:0] prog [$];        // program image indexed by word address
	logic [31:0] model_regs [32];
	int          wait_cnt;
	int          next_idx;        // program index of the next expected retire
	int          errors;
	int          checks;
	int          tests;

	core_top dut0 (
		.clock    (clock),
		.reset    (reset),
		.wb_out   (wb_out),
		.wb_dat_i (wb_dat_i),
		.wb_ack   (wb_ack),
		.retire   (retire)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	function automatic logic [31:0] mem_word(input logic [31:0] adr);
		if (adr[31:2] < prog.size())
			return prog[adr[31:2]];
		return {1'b0, op_ty_j, 25'd0}; // past the end of the program
	endfunction

	// instruction memory slave with 0 to 3 wait states
	always @(posedge clock) begin
		wb_ack <= 1'b0;
		if (reset) begin
			wait_cnt <= 0;
		end else if (wb_out.cyc && wb_out.stb && !wb_ack) begin
			if (wait_cnt == 0) begin
				check("wb_out.we", {31'd0, wb_out.we}, 32'd0);
				wb_ack <= 1'b1;
				wb_dat_i <= mem_word(wb_out.adr);
				wait_cnt <= $urandom_range(3, 0);
			end else begin
				wait_cnt <= wait_cnt - 1;
			end
		end
	end

	function automatic logic [31:0] r_word(input logic [4:0] sub, input logic [4:0] rt,
		input logic [4:0] ra, input logic [4:0] rb);
		return {1'b0, op_ty_base, rt, ra, rb, 5'd0, sub};
	endfunction

	function automatic logic [31:0] i_word(input logic [5:0] opc, input logic [4:0] rt,
		input logic [19:0] imm);
		return {1'b0, opc, rt, imm};
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// ------------------------------------------------------------
	// reference model stepping one instruction per call
	// ------------------------------------------------------------
	task automatic model_step(input logic [31:0] w, output logic [31:0] res,
		output logic ovf, output logic ill);
		logic [5:0]  opc;
		logic [4:0]  sh;
		logic [31:0] a;
		logic [31:0] b;
		opc = w[30:25];
		sh = w[14:10];
		a = model_regs[w[19:15]];
		b = model_regs[w[14:10]];
		res = '0;
		ovf = 1'b0;
		ill = 1'b0;
		if (opc == op_ty_base) begin
			case (w[4:0])
				sub_add: begin
					res = a + b;
					ovf = (a[31] == b[31]) && (res[31] != a[31]);
				end
				sub_sub: begin
					res = a - b;
					ovf = (a[31] != b[31]) && (res[31] != a[31]);
				end
				sub_and:   res = a & b;
				sub_or:    res = a | b;
				sub_xor:   res = a ^ b;
				sub_srli:  res = a >> sh;
				sub_slli:  res = a << sh;
				sub_rotri: res = (sh == 0) ? a : ((a >> sh) | (a << (32 - sh)));
				default:   ill = 1'b1;
			endcase
		end else if (opc == op_addi || opc == op_ori || opc == op_xori) begin
			a = model_regs[w[24:20]]; // rt is source and destination
			if (opc == op_addi) begin
				b = {{17{w[14]}}, w[14:0]};
				res = a + b;
				ovf = (a[31] == b[31]) && (res[31] != a[31]);
			end else begin
				b = {17'd0, w[14:0]};
				res = (opc == op_ori) ? (a | b) : (a ^ b);
			end
		end else if (opc == op_movi) begin
			res = {{12{w[19]}}, w[19:0]};
		end else begin
			ill = 1'b1;
		end
		if (!ill)
			model_regs[w[24:20]] = res;
	endtask

	task automatic wait_retire(output bit ok);
		ok = 1'b0;
		for (int n = 0; n < 100 && !ok; n++) begin
			@(negedge clock);
			ok = retire.valid;
		end
		if (!ok) begin
			errors++;
			$display("timeout at %0t: no retire record within 100 cycles", $time);
		end
	endtask

	task automatic collect(input int count);
		bit          ok;
		logic [31:0] w;
		logic [31:0] res;
		logic        ovf;
		logic        ill;
		repeat (count) begin
			wait_retire(ok);
			if (!ok)
				return;
			w = prog[next_idx];
			model_step(w, res, ovf, ill);
			check("retire.pc", retire.pc, next_idx * 4);
			check("retire.rd", {27'd0, retire.rd}, {27'd0, w[24:20]});
			check("retire.illegal", {31'd0, retire.illegal}, {31'd0, ill});
			if (!ill) begin
				check("retire.result", retire.result, res);
				check("retire.overflow", {31'd0, retire.overflow}, {31'd0, ovf});
			end
			next_idx++;
		end
	endtask

	// three cycles of reset with bus and retire quiet inside it
	task automatic do_reset;
		@(posedge clock);
		reset <= 1'b1;
		repeat (2) @(posedge clock);
		@(negedge clock);
		check("wb_out.cyc", {31'd0, wb_out.cyc}, 32'd0);
		check("wb_out.stb", {31'd0, wb_out.stb}, 32'd0);
		check("retire.valid", {31'd0, retire.valid}, 32'd0);
		@(posedge clock);
		reset <= 1'b0;
		foreach (model_regs[i])
			model_regs[i] = '0;
		next_idx = 0;
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests++;
		$display("test %-16s %0d errors", name, errors - errors_before);
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------
	task automatic test_immediates;
		int e;
		e = errors;
		prog = {};
		prog.push_back(i_word(op_movi, 5'd1, 20'hffffb));
		prog.push_back(i_word(op_movi, 5'd2, 20'h12345));
		prog.push_back(i_word(op_addi, 5'd1, 20'h07ffd)); // -3
		prog.push_back(i_word(op_ori, 5'd2, 20'h04321));
		prog.push_back(i_word(op_xori, 5'd2, 20'h06000));
		prog.push_back(i_word(op_movi, 5'd3, 20'h80000));
		do_reset();
		collect(prog.size());
		finish_test("immediates", e);
	endtask

	task automatic test_arith;
		int e;
		e = errors;
		prog = {};
		prog.push_back(i_word(op_movi, 5'd1, 20'hfffff));
		prog.push_back(r_word(sub_srli, 5'd1, 5'd1, 5'd1)); // r1 = 0x7fffffff
		prog.push_back(i_word(op_movi, 5'd2, 20'h00001));
		prog.push_back(r_word(sub_add, 5'd3, 5'd1, 5'd2));
		prog.push_back(r_word(sub_sub, 5'd4, 5'd3, 5'd2));
		prog.push_back(r_word(sub_add, 5'd5, 5'd3, 5'd3));
		prog.push_back(r_word(sub_add, 5'd6, 5'd1, 5'd1));
		prog.push_back(r_word(sub_add, 5'd7, 5'd2, 5'd2));
		prog.push_back(r_word(sub_sub, 5'd8, 5'd2, 5'd1));
		prog.push_back(r_word(sub_sub, 5'd9, 5'd3, 5'd1));
		prog.push_back(i_word(op_addi, 5'd1, 20'h00001));
		do_reset();
		collect(prog.size());
		finish_test("arith", e);
	endtask

	task automatic test_logic_shifts;
		int          e;
		logic [31:0] r;
		logic [4:0]  amt [4];
		e = errors;
		r = $urandom_range(30, 2);
		amt = '{5'd0, 5'd1, 5'd31, r[4:0]};
		prog = {};
		r = $urandom();
		prog.push_back(i_word(op_movi, 5'd1, r[19:0]));
		prog.push_back(i_word(op_ori, 5'd1, {5'd0, r[31:17]}));
		r = $urandom();
		prog.push_back(i_word(op_movi, 5'd2, r[19:0]));
		prog.push_back(i_word(op_xori, 5'd2, {5'd0, r[31:17]}));
		prog.push_back(r_word(sub_and, 5'd3, 5'd1, 5'd2));
		prog.push_back(r_word(sub_or, 5'd4, 5'd1, 5'd2));
		prog.push_back(r_word(sub_xor, 5'd5, 5'd1, 5'd2));
		foreach (amt[k]) begin
			prog.push_back(r_word(sub_srli, 5'd10, 5'd1, amt[k]));
			prog.push_back(r_word(sub_slli, 5'd11, 5'd1, amt[k]));
			prog.push_back(r_word(sub_rotri, 5'd12, 5'd1, amt[k]));
		end
		do_reset();
		collect(prog.size());
		finish_test("logic_shifts", e);
	endtask

	task automatic test_illegal;
		int e;
		e = errors;
		prog = {};
		prog.push_back(i_word(op_movi, 5'd5, 20'd123));
		prog.push_back(i_word(op_lwi, 5'd5, 20'h0abcd));
		prog.push_back(i_word(op_swi, 5'd5, 20'h0abcd));
		prog.push_back(i_word(op_ty_ls, 5'd5, 20'h12345));
		prog.push_back(i_word(op_ty_b, 5'd5, 20'h00040));
		prog.push_back(i_word(op_ty_j, 5'd5, 20'h00040));
		prog.push_back(i_word(6'b111111, 5'd5, 20'h00001)); // undefined opcode
		prog.push_back(r_word(5'b11111, 5'd5, 5'd5, 5'd5));  // undefined sub-opcode
		prog.push_back(r_word(sub_or, 5'd6, 5'd5, 5'd5));
		do_reset();
		collect(prog.size());
		finish_test("illegal", e);
	endtask

	task automatic test_random_chain;
		int          e;
		int          kind;
		logic [31:0] r;
		logic [4:0]  prev;
		logic [4:0]  subs [8];
		logic [5:0]  imm_ops [3];
		e = errors;
		subs = '{sub_add, sub_sub, sub_and, sub_or, sub_xor, sub_srli, sub_slli, sub_rotri};
		imm_ops = '{op_addi, op_ori, op_xori};
		prog = {};
		r = $urandom();
		prog.push_back(i_word(op_movi, 5'd1, r[19:0]));
		prev = 5'd1;
		repeat (30) begin
			r = $urandom();
			kind = $urandom_range(10, 0);
			if (kind < 8) begin
				prog.push_back(r_word(subs[kind], r[24:20], prev, r[14:10]));
				prev = r[24:20];
			end else begin
				prog.push_back(i_word(imm_ops[kind - 8], prev, {5'd0, r[14:0]}));
			end
		end
		do_reset();
		collect(prog.size());
		finish_test("random_chain", e);
	endtask

	task automatic test_reset;
		int e;
		e = errors;
		prog = {};
		repeat (4) begin
			prog.push_back(r_word(sub_or, 5'd7, 5'd3, 5'd3));
			prog.push_back(i_word(op_addi, 5'd3, 20'h00055));
		end
		do_reset();
		collect(3);
		do_reset(); // in the middle of the program
		for (int n = 0; n < 20 && !wb_out.stb; n++)
			@(negedge clock);
		if (!wb_out.stb) begin
			errors++;
			$display("timeout at %0t: no bus request after reset", $time);
		end
		check("wb_out.adr", wb_out.adr, 32'd0);
		collect(3); // first retire reads r3 which reset cleared
		finish_test("reset", e);
	endtask

	initial begin
		reset = 1'b1;
		wb_ack = 1'b0;
		wb_dat_i = '0;
		errors = 0;
		checks = 0;
		tests = 0;
		void'($urandom(32'hc4c3_dff0));
		test_immediates();
		test_arith();
		test_logic_shifts();
		test_illegal();
		test_random_chain();
		test_reset();
		$display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
			tests, checks, errors, dut0.u_assert.assert_failures);
		if (errors == 0 && dut0.u_assert.assert_failures == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
cpu_pkg.sv
alu.sv
instr_decoder.sv
regfile.sv
fetch_unit.sv
execute_stage.sv
core_top.sv
core_assertions.sv
core_tb.sv

// File: Bender.yml
package:
  name: mini_core

sources:
  - cpu_pkg.sv
  - alu.sv
  - instr_decoder.sv
  - regfile.sv
  - fetch_unit.sv
  - execute_stage.sv
  - core_top.sv
  - target: test
    files:
      - core_assertions.sv
      - core_tb.sv
